// ==== src.f ====
+incdir+hw
hw/mpu_spi_pkg.sv
hw/spi_byte_xfer.sv
hw/mpu_reg_read.sv
hw/mpu_sample_read.sv
hw/mpu_spi_top.sv
testbench/mpu_slave_model.sv
testbench/mpu_spi_checker.sv
testbench/mpu_spi_assert.sv
testbench/tb_mpu_spi.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mpu_spi
FILELIST   := src.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_mpu_spi.sv ====
// Testbench top for the MPU9250 SPI reader with clock, reset, random requests and summary
`timescale 1ns/10ps
`include "mpu_spi_defines.svh"

module tb_mpu_spi
  import mpu_spi_pkg::*;
();

  localparam int NUM_RAND     = 40;
  localparam int DONE_TIMEOUT = 4000;
  localparam int CS_TIMEOUT   = 200;

  logic                           clk;
  logic                           rst;
  logic                           start;
  mpu_addr_t                      base_addr;
  logic                           miso;
  logic                           sclk;
  logic                           mosi;
  logic                           cs_n;
  logic                           busy;
  logic                           done;
  spi_byte_t [`MPU_BURST_LEN-1:0] sample;
  int                             error_cnt;
  int                             done_cnt;
  int                             req_cnt;
  int                             stray_cnt;
  logic                           timed_out;

  always #10 clk = ~clk;

  mpu_spi_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .base_addr (base_addr),
    .miso      (miso),
    .sclk      (sclk),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .busy      (busy),
    .done      (done),
    .sample    (sample)
  );

  mpu_slave_model slave0 (
    .cs_n (cs_n),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  mpu_spi_checker chk0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .base_addr (base_addr),
    .busy      (busy),
    .done      (done),
    .cs_n      (cs_n),
    .sclk      (sclk),
    .mosi      (mosi),
    .sample    (sample),
    .error_cnt (error_cnt),
    .done_cnt  (done_cnt)
  );

  task automatic set_reg(input mpu_addr_t addr, input spi_byte_t val);
    slave0.regs[addr] = val;
    chk0.regs[addr]   = val;
  endtask

  task automatic load_registers();
    mpu_addr_t addr;
    addr = '0;
    repeat (128) begin
      set_reg(addr, spi_byte_t'($urandom));
      addr = addr + 1'b1;
    end
    set_reg(7'h10, 8'h00);
    set_reg(7'h11, 8'hff);
  endtask

  task automatic wait_done();
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      got = done;
      cycles++;
    end
    if (!got) begin
      $display("Timeout: no done pulse within %0d cycles of request %0d", DONE_TIMEOUT, req_cnt);
      timed_out = 1'b1;
    end
  endtask

  // Second start inside a frame that the DUT must ignore
  task automatic inject_stray_start();
    int   cycles;
    logic hit;
    repeat ($urandom_range(120, 1)) @(posedge clk);
    cycles = 0;
    hit    = 1'b0;
    while (!hit && cycles < CS_TIMEOUT) begin
      @(posedge clk);
      if (!cs_n && busy) begin
        hit = 1'b1;
        start     <= 1'b1;
        base_addr <= mpu_addr_t'($urandom);
      end
      cycles++;
    end
    if (hit) begin
      @(posedge clk);
      start <= 1'b0;
      stray_cnt++;
    end else begin
      $display("Timeout: chip select never went low for a stray start");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_request(input mpu_addr_t base, input logic with_stray);
    @(posedge clk);
    start     <= 1'b1;
    base_addr <= base;
    @(posedge clk);
    start     <= 1'b0;
    base_addr <= mpu_addr_t'($urandom);
    if (with_stray)
      inject_stray_start();
    if (!timed_out)
      wait_done();
    req_cnt++;
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    start     = 1'b0;
    base_addr = '0;
    req_cnt   = 0;
    stray_cnt = 0;
    timed_out = 1'b0;
    void'($urandom(27549));
    load_registers();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // Lanes 2 and 3 hit the 00 and ff registers
    run_request(7'h0e, 1'b0);
    // Address run wraps past 7f
    if (!timed_out)
      run_request(7'h7d, 1'b1);
    for (int i = 0; i < NUM_RAND && !timed_out; i++) begin
      run_request(mpu_addr_t'($urandom), 1'($urandom_range(1)));
    end
    repeat (10) @(posedge clk);
    $display("Summary: %0d requests, %0d stray starts, %0d done pulses, %0d errors, %0d %s",
             req_cnt, stray_cnt, done_cnt, error_cnt, dut0.u_assert.fail_cnt,
             "assertion failures");
    if (timed_out || error_cnt != 0 || dut0.u_assert.fail_cnt != 0) begin
      $display("Some tests failed");
    end else begin
      $display("All tests passed");
    end
    $finish;
  end

endmodule

// ==== testbench/mpu_spi_assert.sv ====
// Concurrent assertions on the MPU9250 SPI reader pins and strobes
`timescale 1ns/10ps

module mpu_spi_assert (
  input logic clk,
  input logic rst,
  input logic cs_n,
  input logic sclk,
  input logic busy,
  input logic done
);

  int fail_cnt;

  initial fail_cnt = 0;

  // Mode 3 keeps sclk high between frames
  sclk_idle_high: assert property (@(posedge clk) disable iff (rst) cs_n |-> sclk)
    else begin
      fail_cnt++;
      $error("sclk low while chip select is high");
    end

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_cnt++;
      $error("done held for more than one cycle");
    end

  idle_after_done: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
    else begin
      fail_cnt++;
      $error("busy still high after done");
    end

endmodule

bind mpu_spi_top mpu_spi_assert u_assert (
  .clk  (clk),
  .rst  (rst),
  .cs_n (cs_n),
  .sclk (sclk),
  .busy (busy),
  .done (done)
);

// ==== testbench/mpu_spi_checker.sv ====
// Checker of the MPU9250 SPI reader for frame decoding, frame count and sample content
`timescale 1ns/10ps
`include "mpu_spi_defines.svh"

module mpu_spi_checker
  import mpu_spi_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  mpu_addr_t                      base_addr,
  input  logic                           busy,
  input  logic                           done,
  input  logic                           cs_n,
  input  logic                           sclk,
  input  logic                           mosi,
  input  spi_byte_t [`MPU_BURST_LEN-1:0] sample,
  output int                             error_cnt,
  output int                             done_cnt
);

  // Reference register contents loaded by the testbench top
  spi_byte_t   regs [128];
  mpu_addr_t   req_base;
  mpu_addr_t   frame_addr;
  logic        pending;
  logic        started;
  logic        cs_prev;
  logic        sclk_prev;
  int          frame_cnt;
  int          rise_cnt;
  logic [15:0] frame_bits;

  task automatic report_error(input string msg);
    error_cnt++;
    $display("error %0t: %s", $time, msg);
  endtask

  // Command byte comes first and the dummy byte second
  task automatic check_frame();
    mpu_cmd_t cmd;
    cmd.raw = frame_bits[15:8];
    if (!pending)
      report_error("chip select frame outside a request");
    if (frame_cnt >= `MPU_BURST_LEN)
      report_error($sformatf("extra frame %0d in one request", frame_cnt));
    if (rise_cnt != 16)
      report_error($sformatf("frame has %0d sclk rising edges, expected 16", rise_cnt));
    if (cmd.fld.rd_flag !== 1'b1)
      report_error("read flag not set in command byte");
    if (cmd.fld.addr !== frame_addr)
      report_error($sformatf("command address %h, expected %h", cmd.fld.addr, frame_addr));
    if (frame_bits[7:0] !== 8'h00)
      report_error($sformatf("dummy byte %h, expected 00", frame_bits[7:0]));
    frame_addr = frame_addr + 1'b1;
    frame_cnt++;
  endtask

  task automatic compare_sample();
    spi_byte_t [`MPU_BURST_LEN-1:0] got;
    mpu_addr_t                      addr;
    got  = sample;
    addr = req_base;
    if (frame_cnt != `MPU_BURST_LEN)
      report_error($sformatf("%0d frames before done, expected %0d", frame_cnt,
                             `MPU_BURST_LEN));
    for (int lane = 0; lane < `MPU_BURST_LEN; lane++) begin
      if (got[0] !== regs[addr])
        report_error($sformatf("sample lane %0d is %h, expected %h", lane, got[0], regs[addr]));
      got  = got >> 8;
      addr = addr + 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      error_cnt = 0;
      done_cnt  = 0;
      pending   = 1'b0;
      started   = 1'b0;
      cs_prev   = 1'b1;
      sclk_prev = 1'b1;
      frame_cnt = 0;
      rise_cnt  = 0;
    end else begin
      // Pins and strobes stay idle until the first request
      if (!started && (cs_n !== 1'b1 || sclk !== 1'b1 || busy !== 1'b0 || done !== 1'b0))
        report_error("outputs not idle after reset");
      if (cs_prev && !cs_n) begin
        rise_cnt   = 0;
        frame_bits = '0;
      end
      if (!cs_n && !sclk_prev && sclk) begin
        frame_bits = {frame_bits[14:0], mosi};
        rise_cnt++;
      end
      if (!cs_prev && cs_n)
        check_frame();
      if (done) begin
        done_cnt++;
        if (pending)
          compare_sample();
        else
          report_error("done pulse without a request");
        pending = 1'b0;
      end
      // Only a start while idle opens a request
      if (start && !busy) begin
        req_base   = base_addr;
        frame_addr = base_addr;
        frame_cnt  = 0;
        pending    = 1'b1;
        started    = 1'b1;
      end
      cs_prev   = cs_n;
      sclk_prev = sclk;
    end
  end

endmodule

// ==== testbench/mpu_slave_model.sv ====
// Behavioral MPU9250 SPI slave in mode 3 with a 128 byte register file
`timescale 1ns/10ps

module mpu_slave_model
  import mpu_spi_pkg::*;
(
  input  logic cs_n,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  // Contents are loaded by the testbench top
  spi_byte_t regs [128];
  spi_byte_t cmd_sr;
  spi_byte_t rd_sr;
  mpu_cmd_t  cmd;
  int        rise_cnt;
  int        fall_cnt;

  initial begin
    miso     = 1'b0;
    rise_cnt = 0;
    fall_cnt = 0;
  end

  always @(posedge sclk or negedge sclk or posedge cs_n) begin
    if (cs_n !== 1'b0) begin
      rise_cnt = 0;
      fall_cnt = 0;
      miso     = 1'b0;
    end else if (sclk) begin
      // Command bits come in MSB first on rising sclk
      if (rise_cnt < 8) begin
        cmd_sr = {cmd_sr[6:0], mosi};
      end
      rise_cnt++;
      if (rise_cnt == 8) begin
        cmd.raw = cmd_sr;
        rd_sr   = cmd.fld.rd_flag ? regs[cmd.fld.addr] : 8'h00;
      end
    end else begin
      // Data byte goes out during the second byte of the frame
      if (fall_cnt >= 8) begin
        miso  = rd_sr[7];
        rd_sr = {rd_sr[6:0], 1'b0};
      end
      fall_cnt++;
    end
  end

endmodule

// ==== hw/mpu_spi_top.sv ====
// MPU9250 SPI reader top that connects the sample reader to the SPI pins
`timescale 1ns/10ps
`include "mpu_spi_defines.svh"

module mpu_spi_top
  import mpu_spi_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  mpu_addr_t                       base_addr,
  input  logic                            miso,
  output logic                            sclk,
  output logic                            mosi,
  output logic                            cs_n,
  output logic                            busy,
  output logic                            done,
  output spi_byte_t [`MPU_BURST_LEN-1:0]  sample
);

  mpu_sample_read u_sample_read (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .base_addr (base_addr),
    .miso      (miso),
    .sclk      (sclk),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .busy      (busy),
    .done      (done),
    .sample    (sample)
  );

endmodule

// ==== hw/mpu_sample_read.sv ====
// MPU9250 sample reader that reads a run of consecutive registers into one sample word
`timescale 1ns/10ps
`include "mpu_spi_defines.svh"

module mpu_sample_read
  import mpu_spi_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  mpu_addr_t                       base_addr,
  input  logic                            miso,
  output logic                            sclk,
  output logic                            mosi,
  output logic                            cs_n,
  output logic                            busy,
  output logic                            done,
  output spi_byte_t [`MPU_BURST_LEN-1:0]  sample
);

  localparam int IDX_W = $clog2(`MPU_BURST_LEN + 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`MPU_BURST_LEN - 1);

  logic             run;
  logic [IDX_W-1:0] idx;
  mpu_addr_t        addr;
  logic             reg_start;
  logic             reg_busy;
  logic             reg_done;
  spi_byte_t        reg_data;

  assign busy = run | reg_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      run       <= 1'b0;
      idx       <= '0;
      reg_start <= 1'b0;
      done      <= 1'b0;
    end else begin
      reg_start <= 1'b0;
      done      <= 1'b0;
      if (!run) begin
        if (start) begin
          run       <= 1'b1;
          idx       <= '0;
          reg_start <= 1'b1;
        end
      end else if (reg_done) begin
        if (idx == LAST_IDX) begin
          run  <= 1'b0;
          done <= 1'b1;
        end else begin
          idx       <= idx + 1'b1;
          reg_start <= 1'b1;
        end
      end
    end
  end

  // Address wraps within 7 bits
  // Lane 0 holds the first register
  always_ff @(posedge clk) begin
    if (!run && start) begin
      addr <= base_addr;
    end else if (run && reg_done) begin
      addr <= addr + 1'b1;
    end
    if (run && reg_done) begin
      sample[idx] <= reg_data;
    end
  end

  mpu_reg_read u_reg_read (
    .clk       (clk),
    .rst       (rst),
    .reg_start (reg_start),
    .reg_addr  (addr),
    .miso      (miso),
    .sclk      (sclk),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .reg_busy  (reg_busy),
    .reg_done  (reg_done),
    .reg_data  (reg_data)
  );

endmodule

// ==== hw/mpu_reg_read.sv ====
// MPU9250 single register read with chip select framing around a command and a data byte
`timescale 1ns/10ps

module mpu_reg_read
  import mpu_spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      reg_start,
  input  mpu_addr_t reg_addr,
  input  logic      miso,
  output logic      sclk,
  output logic      mosi,
  output logic      cs_n,
  output logic      reg_busy,
  output logic      reg_done,
  output spi_byte_t reg_data
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CMD  = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0] state;
  mpu_cmd_t   cmd;
  logic       xfer_start;
  spi_byte_t  tx_byte;
  logic       xfer_busy;
  logic       xfer_finish;
  spi_byte_t  rx_byte;

  // Read command for the requested register
  always_comb begin
    cmd.fld.rd_flag = 1'b1;
    cmd.fld.addr    = reg_addr;
  end

  assign reg_busy = (state != ST_IDLE) | xfer_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      cs_n       <= 1'b1;
      xfer_start <= 1'b0;
      reg_done   <= 1'b0;
    end else begin
      xfer_start <= 1'b0;
      reg_done   <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (reg_start) begin
            cs_n       <= 1'b0;
            xfer_start <= 1'b1;
            state      <= ST_CMD;
          end
        end
        // Dummy byte follows the command right away
        ST_CMD: begin
          if (xfer_finish) begin
            xfer_start <= 1'b1;
            state      <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (xfer_finish) begin
            cs_n     <= 1'b1;
            reg_done <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && reg_start) begin
      tx_byte <= cmd.raw;
    end else if ((state == ST_CMD) && xfer_finish) begin
      tx_byte <= '0;
    end
    if ((state == ST_DATA) && xfer_finish) begin
      reg_data <= rx_byte;
    end
  end

  spi_byte_xfer u_byte_xfer (
    .clk     (clk),
    .rst     (rst),
    .start   (xfer_start),
    .miso    (miso),
    .tx_byte (tx_byte),
    .sclk    (sclk),
    .mosi    (mosi),
    .busy    (xfer_busy),
    .finish  (xfer_finish),
    .rx_byte (rx_byte)
  );

endmodule

// ==== hw/spi_byte_xfer.sv ====
// SPI mode-3 byte engine that shifts a byte out on mosi while shifting a byte in from miso
`timescale 1ns/10ps
`include "mpu_spi_defines.svh"

module spi_byte_xfer
  import mpu_spi_pkg::*;
#(
  parameter int CLK_DIV = `MPU_CLK_DIV
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      miso,
  input  spi_byte_t tx_byte,
  output logic      sclk,
  output logic      mosi,
  output logic      busy,
  output logic      finish,
  output spi_byte_t rx_byte
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_LEAD = 2'd1;
  localparam logic [1:0] ST_XFER = 2'd2;

  // Prescale counter points inside one bit period
  localparam logic [CLK_DIV-1:0] HALF_M1 = {1'b0, {(CLK_DIV-1){1'b1}}};
  localparam logic [CLK_DIV-1:0] HALF    = {1'b1, {(CLK_DIV-1){1'b0}}};
  localparam logic [CLK_DIV-1:0] LAST    = {CLK_DIV{1'b1}};

  logic [1:0]         state;
  logic [CLK_DIV-1:0] div_cnt;
  logic [2:0]         bit_cnt;
  spi_byte_t          shreg;
  logic               rise_edge;
  logic               byte_end;

  assign busy = (state != ST_IDLE);

  // sclk goes high on the next clock, so miso is taken here
  assign rise_edge = (state == ST_XFER) && (div_cnt == HALF_M1);

  // One cycle after the eighth rising edge
  assign byte_end = (state == ST_XFER) && (div_cnt == HALF) && (bit_cnt == 3'd7);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b1;
      mosi    <= 1'b0;
      finish  <= 1'b0;
    end else begin
      finish <= 1'b0;
      case (state)
        ST_IDLE: begin
          div_cnt <= '0;
          bit_cnt <= '0;
          if (start) begin
            state <= ST_LEAD;
          end
        end
        // Half-bit lead-in with sclk still high
        ST_LEAD: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == HALF_M1) begin
            div_cnt <= '0;
            state   <= ST_XFER;
            sclk    <= 1'b0;
            mosi    <= shreg[7];
          end
        end
        ST_XFER: begin
          div_cnt <= div_cnt + 1'b1;
          if (rise_edge) begin
            sclk <= 1'b1;
          end else if (byte_end) begin
            finish <= 1'b1;
            mosi   <= 1'b0;
            state  <= ST_IDLE;
          end else if (div_cnt == LAST) begin
            // Falling edge opens the next bit
            sclk    <= 1'b0;
            mosi    <= shreg[7];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Shift register and received byte
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && start) begin
      shreg <= tx_byte;
    end else if (rise_edge) begin
      shreg <= {shreg[6:0], miso};
    end
    if (byte_end) begin
      rx_byte <= shreg;
    end
  end

endmodule

// ==== hw/mpu_spi_pkg.sv ====
// Shared types of the MPU9250 SPI reader for data byte, register address and command byte
`include "mpu_spi_defines.svh"

package mpu_spi_pkg;

  typedef logic [7:0] spi_byte_t;

  // Address takes all bits below the read flag
  typedef logic [`MPU_READ_BIT-1:0] mpu_addr_t;

  // Command byte seen either as a raw byte or as flag plus address
  typedef union packed {
    spi_byte_t raw;
    struct packed {
      logic      rd_flag;
      mpu_addr_t addr;
    } fld;
  } mpu_cmd_t;

endpackage

// ==== hw/mpu_spi_defines.svh ====
// Build parameters of the MPU9250 SPI reader for sclk prescale, burst length and read flag position
`ifndef MPU_SPI_DEFINES_SVH
`define MPU_SPI_DEFINES_SVH

// Width of the sclk prescale counter
// One bit lasts 2**MPU_CLK_DIV cycles
// Must be at least 2
`define MPU_CLK_DIV 2

// Consecutive registers per sample such as ACCEL_XOUT_H to ACCEL_ZOUT_L
`define MPU_BURST_LEN 6

// Read flag position in the command byte
`define MPU_READ_BIT 7

`endif
